// File: mipsCore.f
coreCfgPkg.sv
mipsIsaPkg.sv
fetchDecode.sv
executeStage.sv
memWriteback.sv
mipsCore.sv
tbMipsCore.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it, and looks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tbMipsCore \
   -f mipsCore.f -o simMipsCore
output=$(./obj_dir/simMipsCore)
echo "$output"
if grep -qx "sim passed" <<< "$output"; then
   exit 0
fi
exit 1

// File: mipsCoreGolden.dat
# P <byte address hex> <instruction hex> | S <commit index> starts a 3-cycle stall pulse
# C <destination register decimal> <value hex>, listed in commit order
P 00000000 34011234 # ori   r1, r0, 0x1234
P 00000004 3c028000 # lui   r2, 0x8000
P 00000008 2403fffb # addiu r3, r0, -5
P 0000000c 00232021 # addu  r4, r1, r3
P 00000010 00812823 # subu  r5, r4, r1
P 00000014 00a13024 # and   r6, r5, r1
P 00000018 00c23825 # or    r7, r6, r2
P 0000001c 00e14026 # xor   r8, r7, r1
P 00000020 01004827 # nor   r9, r8, r0
P 00000024 0041502a # slt   r10, r2, r1
P 00000028 0041582b # sltu  r11, r2, r1
P 0000002c 00016100 # sll   r12, r1, 4
P 00000030 000268c2 # srl   r13, r2, 3
P 00000034 000270c3 # sra   r14, r2, 3
P 00000038 286ffffc # slti  r15, r3, -4
P 0000003c 3070ff00 # andi  r16, r3, 0xff00
P 00000040 3831ffff # xori  r17, r1, 0xffff
P 00000044 ac010010 # sw    r1, 16(r0)
P 00000048 ac020014 # sw    r2, 20(r0)
P 0000004c 8c120010 # lw    r18, 16(r0)
P 00000050 8c130014 # lw    r19, 20(r0)
P 00000054 24140007 # addiu r20, r0, 7
P 00000058 0253a821 # addu  r21, r18, r19
P 0000005c 12410002 # beq   r18, r1, +2 taken
P 00000060 24160001 # addiu r22, r0, 1
P 00000064 24160002 # addiu r22, r0, 2 skipped
P 00000068 16410002 # bne   r18, r1, +2 not taken
P 0000006c 24170003 # addiu r23, r0, 3
P 00000070 24180004 # addiu r24, r0, 4
P 00000074 17170002 # bne   r24, r23, +2 taken
P 00000078 24190005 # addiu r25, r0, 5
P 0000007c 24190006 # addiu r25, r0, 6 skipped
P 00000080 13170001 # beq   r24, r23, +1 not taken
P 00000084 241a0008 # addiu r26, r0, 8
P 00000088 0c000028 # jal   0xa0
P 0000008c 241b0009 # addiu r27, r0, 9
P 00000090 0800002c # j     0xb0
P 00000094 26940001 # addiu r20, r20, 1
P 000000a0 241c000a # addiu r28, r0, 10
P 000000a4 03e00008 # jr    r31
P 000000a8 241d000b # addiu r29, r0, 11
P 000000ac 241d000c # addiu r29, r0, 12 skipped
P 000000b0 039df021 # addu  r30, r28, r29
P 000000b4 0800002d # j     0xb4
P 000000b8 00000000 # nop
S 3
S 18
S 26
C 1 00001234
C 2 80000000
C 3 fffffffb
C 4 0000122f
C 5 fffffffb
C 6 00001230
C 7 80001230
C 8 80000004
C 9 7ffffffb
C 10 00000001
C 11 00000000
C 12 00012340
C 13 10000000
C 14 f0000000
C 15 00000001
C 16 0000ff00
C 17 0000edcb
C 18 00001234
C 19 80000000
C 20 00000007
C 21 80001234
C 22 00000001
C 23 00000003
C 24 00000004
C 25 00000005
C 26 00000008
C 31 00000090
C 27 00000009
C 28 0000000a
C 29 0000000b
C 20 00000008
C 30 00000015

// File: tbMipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsCore;

   localparam int resetCycles = 10;
   // Length of one stall pulse
   localparam int stallCycles = 3;
   // Idle cycles after the last commit
   localparam int tailCycles = 10;

   logic clk;
   logic reset;
   logic stall;
   logic progWrite;
   coreCfgPkg::word_t progAddr;
   coreCfgPkg::word_t progData;
   logic commitValid;
   coreCfgPkg::regAddr_t commitReg;
   coreCfgPkg::word_t commitData;

   // Golden file contents
   coreCfgPkg::word_t loadAddr [$];
   coreCfgPkg::word_t loadWord [$];
   coreCfgPkg::regAddr_t expReg [$];
   coreCfgPkg::word_t expData [$];
   int stallAt [$];

   int commitCount = 0;
   int errorCount = 0;
   int passCount = 0;
   int failCount = 0;

   mipsCore dut (
      .clk(clk),
      .reset(reset),
      .stall(stall),
      .progWrite(progWrite),
      .progAddr(progAddr),
      .progData(progData),
      .commitValid(commitValid),
      .commitReg(commitReg),
      .commitData(commitData)
   );

   always #5 clk = ~clk;

   task automatic readGolden();
      int fd;
      int fields;
      int wanted;
      string line;
      string rest;
      logic [7:0] tag;
      coreCfgPkg::word_t first;
      coreCfgPkg::word_t second;
      fd = $fopen("mipsCoreGolden.dat", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file mipsCoreGolden.dat");
         errorCount++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         // Blank lines and comments
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         tag = line.getc(0);
         rest = line.substr(1, line.len() - 1);
         if (tag == "P") begin
            wanted = 2;
            fields = $sscanf(rest, "%h %h", first, second);
            loadAddr.push_back(first);
            loadWord.push_back(second);
         end else if (tag == "C") begin
            wanted = 2;
            fields = $sscanf(rest, "%d %h", first, second);
            expReg.push_back(first[4:0]);
            expData.push_back(second);
         end else if (tag == "S") begin
            // Commit index only
            wanted = 1;
            fields = $sscanf(rest, "%d", first);
            stallAt.push_back(int'(first));
         end else begin
            wanted = 1;
            fields = 0;
         end
         if (fields != wanted) begin
            $display("Golden file line could not be read: %s", line);
            errorCount++;
         end
      end
      $fclose(fd);
      if (loadAddr.size() == 0 || expReg.size() == 0) begin
         $display("Golden file holds no program or no expected commits");
         errorCount++;
      end
   endtask

   task automatic checkReg(input string name, input coreCfgPkg::regAddr_t got,
                           input coreCfgPkg::regAddr_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkWord(input string name, input coreCfgPkg::word_t got,
                            input coreCfgPkg::word_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
         errorCount++;
      end
   endtask

   // Register file writes checked in commit order on the falling edge
   always @(negedge clk) begin
      int errorsBefore;
      if (!reset && commitValid) begin
         if (commitCount < expReg.size()) begin
            errorsBefore = errorCount;
            checkReg("commitReg", commitReg, expReg[commitCount]);
            checkWord("commitData", commitData, expData[commitCount]);
            if (errorCount == errorsBefore) begin
               passCount++;
               $display("commit %0d: r%0d = 0x%08h ok", commitCount, commitReg, commitData);
            end else begin
               failCount++;
               $display("commit %0d: mismatch", commitCount);
            end
         end else begin
            // Skipped or repeated instruction
            failCount++;
            errorCount++;
            $display("Extra commit of r%0d = 0x%08h after the last expected one",
                     commitReg, commitData);
         end
         commitCount++;
      end
   end

   initial begin
      int limit;
      int cycles;
      int stallLeft;
      int nextStall;
      bit timedOut;
      clk = 1'b0;
      reset = 1'b1;
      stall = 1'b1;
      progWrite = 1'b0;
      progAddr = '0;
      progData = '0;
      cycles = 0;
      stallLeft = 0;
      nextStall = 0;
      readGolden();
      // Per word, per stall pulse, plus pipeline fill and the idle loop
      limit = 4 * loadAddr.size() + stallCycles * stallAt.size() + 50;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      // Program load while the core is held by stall
      foreach (loadAddr[i]) begin
         @(posedge clk);
         progWrite <= 1'b1;
         progAddr <= loadAddr[i];
         progData <= loadWord[i];
      end
      @(posedge clk);
      progWrite <= 1'b0;
      // Fetch re-reads word 0 once more
      @(posedge clk);
      stall <= 1'b0;
      while (commitCount < expReg.size() && cycles < limit) begin
         @(posedge clk);
         cycles++;
         if (stallLeft > 0) begin
            stallLeft--;
            if (stallLeft == 0) begin
               stall <= 1'b0;
            end
         end else if (nextStall < stallAt.size() && commitCount >= stallAt[nextStall]) begin
            // Freeze the pipeline mid-run
            stall <= 1'b1;
            stallLeft = stallCycles;
            nextStall++;
         end
      end
      stall <= 1'b0;
      timedOut = (commitCount < expReg.size());
      if (timedOut) begin
         $display("Timeout: only %0d of %0d commits seen within %0d cycles",
                  commitCount, expReg.size(), limit);
      end else begin
         // Idle loop must stay silent
         repeat (tailCycles) @(posedge clk);
      end
      $display("Tests: %0d passed, %0d failed", passCount, failCount);
      if (!timedOut && errorCount == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore #(
   parameter int imemWords = coreCfgPkg::IMEM_WORDS_DEFAULT,
   parameter int dmemWords = coreCfgPkg::DMEM_WORDS_DEFAULT
) (
   input wire clk,
   input wire reset,
   input wire stall,
   input wire progWrite,
   input wire coreCfgPkg::word_t progAddr,
   input wire coreCfgPkg::word_t progData,
   output logic commitValid,
   output coreCfgPkg::regAddr_t commitReg,
   output coreCfgPkg::word_t commitData
);

   // Fetch to execute
   wire exValid, exUseImm, exUseShamt, exRegWrite, exMemRead, exMemWrite;
   wire exBranchEq, exBranchNe, exJump, exJumpReg, exLink;
   wire coreCfgPkg::word_t exPc, exRsVal, exRtVal, exImm;
   wire coreCfgPkg::regAddr_t exRs, exRt, exDest;
   wire mipsIsaPkg::shamt_t exShamt;
   wire mipsIsaPkg::target_t exTarget;
   wire coreCfgPkg::aluOp_t exAluOp;

   // Execute to fetch and memory
   wire redirectValid, memWriteNow;
   wire memValid, memRegWrite, memRead, memWrite, memLink;
   wire coreCfgPkg::word_t redirectPc, memAddr, memWriteData, memPc, memAluOut;
   wire coreCfgPkg::regAddr_t memDest;

   // Write-back to register file and forwarding
   wire wbValid;
   wire coreCfgPkg::regAddr_t wbReg;
   wire coreCfgPkg::word_t wbData;

   fetchDecode #(.imemWords(imemWords)) fetch (.*);

   executeStage execute (.*);

   memWriteback #(.dmemWords(dmemWords)) writeback (.*);

   // Commit trace is the register file write port
   assign commitValid = wbValid;
   assign commitReg = wbReg;
   assign commitData = wbData;

endmodule

`default_nettype wire

// File: memWriteback.sv
`timescale 1ns/10ps
`default_nettype none

module memWriteback #(
   parameter int dmemWords = coreCfgPkg::DMEM_WORDS_DEFAULT
) (
   input wire clk,
   input wire stall,
   // Request from the execute cycle
   input wire coreCfgPkg::word_t memAddr,
   input wire coreCfgPkg::word_t memWriteData,
   input wire memWriteNow,
   input wire memValid,
   input wire coreCfgPkg::word_t memPc,
   input wire coreCfgPkg::regAddr_t memDest,
   input wire coreCfgPkg::word_t memAluOut,
   input wire memRegWrite,
   input wire memRead,
   input wire memWrite,
   input wire memLink,
   output logic wbValid,
   output coreCfgPkg::regAddr_t wbReg,
   output coreCfgPkg::word_t wbData
);

   localparam int addrBits = $clog2(dmemWords);

   coreCfgPkg::word_t dmem [dmemWords];
   coreCfgPkg::word_t readData;

   // Word RAM, byte address dropped to a word index
   always_ff @(posedge clk) begin
      if (memWriteNow) begin
         dmem[memAddr[addrBits+1:2]] <= memWriteData;
      end
      // Hold read data while stalled, forwarding is off then
      if (!stall) begin
         readData <= dmem[memAddr[addrBits+1:2]];
      end
   end

   // No write for stores, r0 or stalled cycles
   assign wbValid = memValid && memRegWrite && !memWrite && memDest != '0 && !stall;
   assign wbReg = memDest;

   always_comb begin
      if (memLink) begin
         // Return past the delay slot
         wbData = memPc + 32'd8;
      end else if (memRead) begin
         wbData = readData;
      end else begin
         wbData = memAluOut;
      end
   end

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage (
   input wire clk,
   input wire reset,
   input wire stall,
   input wire exValid,
   input wire coreCfgPkg::word_t exPc,
   input wire coreCfgPkg::regAddr_t exRs,
   input wire coreCfgPkg::regAddr_t exRt,
   input wire coreCfgPkg::regAddr_t exDest,
   input wire coreCfgPkg::word_t exRsVal,
   input wire coreCfgPkg::word_t exRtVal,
   input wire coreCfgPkg::word_t exImm,
   input wire mipsIsaPkg::shamt_t exShamt,
   input wire coreCfgPkg::aluOp_t exAluOp,
   input wire exUseImm,
   input wire exUseShamt,
   input wire exRegWrite,
   input wire exMemRead,
   input wire exMemWrite,
   input wire exBranchEq,
   input wire exBranchNe,
   input wire exJump,
   input wire exJumpReg,
   input wire exLink,
   input wire mipsIsaPkg::target_t exTarget,
   // Forwarding source
   input wire wbValid,
   input wire coreCfgPkg::regAddr_t wbReg,
   input wire coreCfgPkg::word_t wbData,
   output logic redirectValid,
   output coreCfgPkg::word_t redirectPc,
   // Data memory request in this cycle
   output coreCfgPkg::word_t memAddr,
   output coreCfgPkg::word_t memWriteData,
   output logic memWriteNow,
   output logic memValid,
   output coreCfgPkg::word_t memPc,
   output coreCfgPkg::regAddr_t memDest,
   output coreCfgPkg::word_t memAluOut,
   output logic memRegWrite,
   output logic memRead,
   output logic memWrite,
   output logic memLink
);

   coreCfgPkg::word_t rsFwd;
   coreCfgPkg::word_t rtFwd;
   coreCfgPkg::word_t opA;
   coreCfgPkg::word_t opB;
   coreCfgPkg::word_t aluOut;
   coreCfgPkg::word_t pcPlus4;
   logic taken;

   // Memory stage result into execute, r0 never forwarded
   assign rsFwd = (wbValid && wbReg == exRs && exRs != '0) ? wbData : exRsVal;
   assign rtFwd = (wbValid && wbReg == exRt && exRt != '0) ? wbData : exRtVal;

   // Shift amount or rs, immediate or rt
   assign opA = exUseShamt ? {27'b0, exShamt} : rsFwd;
   assign opB = exUseImm ? exImm : rtFwd;

   always_comb begin
      case (exAluOp)
         coreCfgPkg::ALU_SUB:  aluOut = opA - opB;
         coreCfgPkg::ALU_AND:  aluOut = opA & opB;
         coreCfgPkg::ALU_OR:   aluOut = opA | opB;
         coreCfgPkg::ALU_XOR:  aluOut = opA ^ opB;
         coreCfgPkg::ALU_NOR:  aluOut = ~(opA | opB);
         coreCfgPkg::ALU_SLT:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
         coreCfgPkg::ALU_SLTU: aluOut = {31'b0, opA < opB};
         // Shifts move rt by the amount in A
         coreCfgPkg::ALU_SLL:  aluOut = opB << opA[4:0];
         coreCfgPkg::ALU_SRL:  aluOut = opB >> opA[4:0];
         coreCfgPkg::ALU_SRA:  aluOut = $signed(opB) >>> opA[4:0];
         coreCfgPkg::ALU_LUI:  aluOut = {opB[15:0], 16'b0};
         default:              aluOut = opA + opB;
      endcase
   end

   // Branch compare on forwarded operands
   assign pcPlus4 = exPc + 32'd4;
   assign taken = (exBranchEq && rsFwd == rtFwd) || (exBranchNe && rsFwd != rtFwd);
   assign redirectValid = exValid && (taken || exJump || exJumpReg);

   always_comb begin
      if (exJumpReg) begin
         redirectPc = rsFwd;
      end else if (exJump) begin
         redirectPc = {pcPlus4[31:28], exTarget, 2'b00};
      end else begin
         // Word offset relative to the delay slot
         redirectPc = pcPlus4 + {exImm[29:0], 2'b00};
      end
   end

   // Store issued now so a load reads in the next stage
   assign memAddr = aluOut;
   assign memWriteData = rtFwd;
   assign memWriteNow = exValid && exMemWrite && !stall;

   // Execute to memory, bubble on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         memValid <= 1'b0;
         memRegWrite <= 1'b0;
         memRead <= 1'b0;
         memWrite <= 1'b0;
         memLink <= 1'b0;
      end else if (!stall) begin
         memValid <= exValid;
         memRegWrite <= exRegWrite;
         memRead <= exMemRead;
         memWrite <= exMemWrite;
         memLink <= exLink;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         memPc <= exPc;
         memDest <= exDest;
         memAluOut <= aluOut;
      end
   end

endmodule

`default_nettype wire

// File: fetchDecode.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecode #(
   parameter int imemWords = coreCfgPkg::IMEM_WORDS_DEFAULT
) (
   input wire clk,
   input wire reset,
   input wire stall,
   // Program load, byte address, taken only while stalled
   input wire progWrite,
   input wire coreCfgPkg::word_t progAddr,
   input wire coreCfgPkg::word_t progData,
   // Taken branch or jump from execute
   input wire redirectValid,
   input wire coreCfgPkg::word_t redirectPc,
   // Register file write port
   input wire wbValid,
   input wire coreCfgPkg::regAddr_t wbReg,
   input wire coreCfgPkg::word_t wbData,
   output logic exValid,
   output coreCfgPkg::word_t exPc,
   output coreCfgPkg::regAddr_t exRs,
   output coreCfgPkg::regAddr_t exRt,
   output coreCfgPkg::regAddr_t exDest,
   output coreCfgPkg::word_t exRsVal,
   output coreCfgPkg::word_t exRtVal,
   output coreCfgPkg::word_t exImm,
   output mipsIsaPkg::shamt_t exShamt,
   output coreCfgPkg::aluOp_t exAluOp,
   output logic exUseImm,
   output logic exUseShamt,
   output logic exRegWrite,
   output logic exMemRead,
   output logic exMemWrite,
   output logic exBranchEq,
   output logic exBranchNe,
   output logic exJump,
   output logic exJumpReg,
   output logic exLink,
   output mipsIsaPkg::target_t exTarget
);

   localparam int addrBits = $clog2(imemWords);

   coreCfgPkg::word_t pc;
   coreCfgPkg::word_t pcNext;
   coreCfgPkg::word_t fetchAddr;
   coreCfgPkg::word_t instr;
   coreCfgPkg::word_t imem [imemWords];
   coreCfgPkg::word_t regs [32];
   coreCfgPkg::word_t immExt;
   coreCfgPkg::word_t rsVal;
   coreCfgPkg::word_t rtVal;
   mipsIsaPkg::opcode_t opcode;
   mipsIsaPkg::funct_t funct;
   mipsIsaPkg::imm_t imm;
   coreCfgPkg::regAddr_t rs;
   coreCfgPkg::regAddr_t rt;
   coreCfgPkg::regAddr_t rd;
   coreCfgPkg::regAddr_t dest;
   coreCfgPkg::aluOp_t aluOp;
   logic useImm, useShamt, signExt;
   logic regWrite, memRead, memWrite;
   logic branchEq, branchNe, jump, jumpReg, link;

   // Redirect lands after the delay slot has been fetched
   assign pcNext = redirectValid ? redirectPc : pc + 32'd4;
   // Re-read the current word while stalled
   assign fetchAddr = reset ? '0 : (stall ? pc : pcNext);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (!stall) begin
         pc <= pcNext;
      end
   end

   // Instruction RAM, synchronous read
   always_ff @(posedge clk) begin
      if (progWrite && stall) begin
         imem[progAddr[addrBits+1:2]] <= progData;
      end
      instr <= imem[fetchAddr[addrBits+1:2]];
   end

   // Field slices
   assign opcode = instr[31:26];
   assign rs = instr[25:21];
   assign rt = instr[20:16];
   assign rd = instr[15:11];
   assign funct = instr[5:0];
   assign imm = instr[15:0];

   // Control decode
   always_comb begin
      aluOp = coreCfgPkg::ALU_ADD;
      useImm = 1'b1;
      useShamt = 1'b0;
      dest = rt;
      branchEq = 1'b0;
      branchNe = 1'b0;
      jump = 1'b0;
      jumpReg = 1'b0;
      link = 1'b0;
      memRead = (opcode == mipsIsaPkg::OP_LW);
      memWrite = (opcode == mipsIsaPkg::OP_SW);
      // I-types writing rt
      regWrite = opcode inside {mipsIsaPkg::OP_ADDIU, mipsIsaPkg::OP_SLTI, mipsIsaPkg::OP_ANDI,
                                mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_XORI, mipsIsaPkg::OP_LUI,
                                mipsIsaPkg::OP_LW};
      // Logical immediates are zero extended
      signExt = !(opcode inside {mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_XORI});
      case (opcode)
         mipsIsaPkg::OP_RTYPE: begin
            useImm = 1'b0;
            regWrite = 1'b1;
            dest = rd;
            // Shift amount from the shamt field
            useShamt = funct inside {mipsIsaPkg::FN_SLL, mipsIsaPkg::FN_SRL, mipsIsaPkg::FN_SRA};
            case (funct)
               mipsIsaPkg::FN_SLL:  aluOp = coreCfgPkg::ALU_SLL;
               mipsIsaPkg::FN_SRL:  aluOp = coreCfgPkg::ALU_SRL;
               mipsIsaPkg::FN_SRA:  aluOp = coreCfgPkg::ALU_SRA;
               mipsIsaPkg::FN_ADDU: aluOp = coreCfgPkg::ALU_ADD;
               mipsIsaPkg::FN_SUBU: aluOp = coreCfgPkg::ALU_SUB;
               mipsIsaPkg::FN_AND:  aluOp = coreCfgPkg::ALU_AND;
               mipsIsaPkg::FN_OR:   aluOp = coreCfgPkg::ALU_OR;
               mipsIsaPkg::FN_XOR:  aluOp = coreCfgPkg::ALU_XOR;
               mipsIsaPkg::FN_NOR:  aluOp = coreCfgPkg::ALU_NOR;
               mipsIsaPkg::FN_SLT:  aluOp = coreCfgPkg::ALU_SLT;
               mipsIsaPkg::FN_SLTU: aluOp = coreCfgPkg::ALU_SLTU;
               mipsIsaPkg::FN_JR: begin
                  jumpReg = 1'b1;
                  regWrite = 1'b0;
               end
               // Link into rd
               mipsIsaPkg::FN_JALR: begin
                  jumpReg = 1'b1;
                  link = 1'b1;
               end
               default: regWrite = 1'b0;
            endcase
         end
         mipsIsaPkg::OP_J: jump = 1'b1;
         mipsIsaPkg::OP_JAL: begin
            jump = 1'b1;
            link = 1'b1;
            regWrite = 1'b1;
            dest = coreCfgPkg::LINK_REG;
         end
         mipsIsaPkg::OP_BEQ: branchEq = 1'b1;
         mipsIsaPkg::OP_BNE: branchNe = 1'b1;
         mipsIsaPkg::OP_SLTI: aluOp = coreCfgPkg::ALU_SLT;
         mipsIsaPkg::OP_ANDI: aluOp = coreCfgPkg::ALU_AND;
         mipsIsaPkg::OP_ORI: aluOp = coreCfgPkg::ALU_OR;
         mipsIsaPkg::OP_XORI: aluOp = coreCfgPkg::ALU_XOR;
         mipsIsaPkg::OP_LUI: aluOp = coreCfgPkg::ALU_LUI;
         mipsIsaPkg::OP_ADDIU, mipsIsaPkg::OP_LW, mipsIsaPkg::OP_SW: aluOp = coreCfgPkg::ALU_ADD;
         // Unknown opcode behaves as a nop
         default: regWrite = 1'b0;
      endcase
   end

   assign immExt = signExt ? {{16{imm[15]}}, imm} : {16'b0, imm};

   // Register read, r0 hardwired, write-back bypassed in
   function automatic coreCfgPkg::word_t readPort(input coreCfgPkg::regAddr_t idx);
      if (idx == '0) begin
         return '0;
      end else if (wbValid && wbReg == idx) begin
         return wbData;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rsVal = readPort(rs);
      rtVal = readPort(rt);
   end

   // wbValid already excludes r0 and stalled cycles
   always_ff @(posedge clk) begin
      if (wbValid) begin
         regs[wbReg] <= wbData;
      end
   end

   // Fetch to execute, controls cleared to a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         exValid <= 1'b0;
         exRegWrite <= 1'b0;
         exMemRead <= 1'b0;
         exMemWrite <= 1'b0;
         exBranchEq <= 1'b0;
         exBranchNe <= 1'b0;
         exJump <= 1'b0;
         exJumpReg <= 1'b0;
         exLink <= 1'b0;
      end else if (!stall) begin
         exValid <= 1'b1;
         exRegWrite <= regWrite;
         exMemRead <= memRead;
         exMemWrite <= memWrite;
         exBranchEq <= branchEq;
         exBranchNe <= branchNe;
         exJump <= jump;
         exJumpReg <= jumpReg;
         exLink <= link;
      end
   end

   // Payload fields
   always_ff @(posedge clk) begin
      if (!stall) begin
         exPc <= pc;
         exRs <= rs;
         exRt <= rt;
         exDest <= dest;
         exRsVal <= rsVal;
         exRtVal <= rtVal;
         exImm <= immExt;
         exShamt <= instr[10:6];
         exAluOp <= aluOp;
         exUseImm <= useImm;
         exUseShamt <= useShamt;
         exTarget <= instr[25:0];
      end
   end

endmodule

`default_nettype wire

// File: mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

   // Instruction fields
   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;
   typedef logic [15:0] imm_t;
   typedef logic [25:0] target_t;
   typedef logic [4:0] shamt_t;

   // Primary opcodes, bits 31:26
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_JAL   = 6'h03;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_BNE   = 6'h05;
   localparam opcode_t OP_ADDIU = 6'h09;
   localparam opcode_t OP_SLTI  = 6'h0a;
   localparam opcode_t OP_ANDI  = 6'h0c;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_XORI  = 6'h0e;
   localparam opcode_t OP_LUI   = 6'h0f;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;

   // R-type function codes, bits 5:0
   localparam funct_t FN_SLL  = 6'h00;
   localparam funct_t FN_SRL  = 6'h02;
   localparam funct_t FN_SRA  = 6'h03;
   localparam funct_t FN_JR   = 6'h08;
   localparam funct_t FN_JALR = 6'h09;
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_XOR  = 6'h26;
   localparam funct_t FN_NOR  = 6'h27;
   localparam funct_t FN_SLT  = 6'h2a;
   localparam funct_t FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// File: coreCfgPkg.sv
`default_nettype none

package coreCfgPkg;

   // Datapath words: data, byte address and instruction
   typedef logic [31:0] word_t;

   // Register file index
   typedef logic [4:0] regAddr_t;

   // ALU operations chosen by the decoder
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } aluOp_t;

   // Memory depths in words
   localparam int IMEM_WORDS_DEFAULT = 256;
   localparam int DMEM_WORDS_DEFAULT = 256;

   // Return address register for JAL
   localparam regAddr_t LINK_REG = 5'd31;

endpackage

`default_nettype wire
